/* include/alu_config.svh */
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// datapath widths
`define ALU_WORD_W    16
`define ALU_BYTE_W    8
`define ALU_PROD_W    32

// shift count and single-bit index
`define ALU_CNT_W     5
`define ALU_BIT_IDX_W 4

`endif

/* src/alu_flags_pkg.sv */
`include "alu_config.svh"

package alu_flags_pkg;

    typedef struct packed {
        logic cy;   // carry / borrow
        logic p;    // parity of low byte
        logic ac;   // auxiliary carry
        logic z;
        logic s;
        logic v;    // signed overflow
    } alu_flags_t;

    // what one execution unit hands to the merge register
    typedef struct packed {
        logic                   valid;  // unit owns this opcode
        logic [`ALU_PROD_W-1:0] res;
        alu_flags_t             flags;  // new flag values
        alu_flags_t             mask;   // which of them get written
        logic                   psz;    // merge stage fills in p, s, z
    } alu_unit_out_t;

endpackage

/* src/alu_op_pkg.sv */
`include "alu_config.svh"

package alu_op_pkg;

    // the stimulus file refers to these codes by number
    typedef enum logic [4:0] {
        ALU_OP_ADD   = 5'd0,
        ALU_OP_ADDC  = 5'd1,
        ALU_OP_INC   = 5'd2,
        ALU_OP_SUB   = 5'd3,
        ALU_OP_SUBC  = 5'd4,
        ALU_OP_CMP   = 5'd5,
        ALU_OP_DEC   = 5'd6,
        ALU_OP_NEG   = 5'd7,
        ALU_OP_AND   = 5'd8,
        ALU_OP_OR    = 5'd9,
        ALU_OP_XOR   = 5'd10,
        ALU_OP_NOT   = 5'd11,
        ALU_OP_SET1  = 5'd12,
        ALU_OP_CLR1  = 5'd13,
        ALU_OP_NOT1  = 5'd14,
        ALU_OP_TEST1 = 5'd15,
        ALU_OP_ROL   = 5'd16,
        ALU_OP_ROLC  = 5'd17,
        ALU_OP_ROR   = 5'd18,
        ALU_OP_RORC  = 5'd19,
        ALU_OP_SHL   = 5'd20,
        ALU_OP_SHR   = 5'd21,
        ALU_OP_SHRA  = 5'd22,
        ALU_OP_MULU  = 5'd23,
        ALU_OP_MUL   = 5'd24
    } alu_op_e;

    typedef struct packed {
        alu_op_e                  op;
        logic [`ALU_WORD_W-1:0]   ta;
        logic [`ALU_WORD_W-1:0]   tb;
        logic                     wide;     // word mode when set
        alu_flags_pkg::alu_flags_t flags_in;
    } alu_req_t;

endpackage

/* src/alu_arith.sv */
`timescale 1ns/100ps
`include "alu_config.svh"

module alu_arith (
    input  alu_op_pkg::alu_req_t          req,
    output alu_flags_pkg::alu_unit_out_t  unit_out
);

    logic                   hit;
    logic                   is_sub;
    logic                   keep_cy;   // inc and dec leave carry alone
    logic                   carry_in;
    logic [`ALU_WORD_W-1:0] a_op;
    logic [`ALU_WORD_W-1:0] b_op;
    logic [`ALU_WORD_W-1:0] a_m;
    logic [`ALU_WORD_W-1:0] b_m;
    logic [`ALU_WORD_W:0]   sum;
    logic [4:0]             nib;
    logic                   top_a;
    logic                   top_b;
    logic                   top_r;
    logic                   ovf;

    always_comb begin
        hit      = 1'b1;
        is_sub   = 1'b0;
        keep_cy  = 1'b0;
        carry_in = 1'b0;
        a_op     = req.ta;
        b_op     = req.tb;
        case (req.op)
            alu_op_pkg::ALU_OP_ADD: ;
            alu_op_pkg::ALU_OP_ADDC: carry_in = req.flags_in.cy;
            alu_op_pkg::ALU_OP_INC: begin
                b_op    = 16'd1;
                keep_cy = 1'b1;
            end
            alu_op_pkg::ALU_OP_SUB, alu_op_pkg::ALU_OP_CMP: is_sub = 1'b1;
            alu_op_pkg::ALU_OP_SUBC: begin
                is_sub   = 1'b1;
                carry_in = req.flags_in.cy;     // borrow in
            end
            alu_op_pkg::ALU_OP_DEC: begin
                is_sub  = 1'b1;
                b_op    = 16'd1;
                keep_cy = 1'b1;
            end
            alu_op_pkg::ALU_OP_NEG: begin
                // 0 - ta so a borrow means a nonzero operand
                is_sub = 1'b1;
                a_op   = '0;
                b_op   = req.ta;
            end
            default: hit = 1'b0;
        endcase
    end

    // in byte mode the upper byte is cleared so bit 8 is the carry
    assign a_m = req.wide ? a_op : {8'd0, a_op[`ALU_BYTE_W-1:0]};
    assign b_m = req.wide ? b_op : {8'd0, b_op[`ALU_BYTE_W-1:0]};

    assign sum = is_sub ? ({1'b0, a_m} - {1'b0, b_m} - {16'd0, carry_in})
                        : ({1'b0, a_m} + {1'b0, b_m} + {16'd0, carry_in});
    assign nib = is_sub ? ({1'b0, a_m[3:0]} - {1'b0, b_m[3:0]} - {4'd0, carry_in})
                        : ({1'b0, a_m[3:0]} + {1'b0, b_m[3:0]} + {4'd0, carry_in});

    assign top_a = req.wide ? a_op[15] : a_op[7];
    assign top_b = req.wide ? b_op[15] : b_op[7];
    assign top_r = req.wide ? sum[15] : sum[7];
    assign ovf   = is_sub ? ((top_a ^ top_b) & (top_a ^ top_r))
                          : ((top_a ^ top_r) & (top_b ^ top_r));

    always_comb begin
        unit_out          = '0;
        unit_out.valid    = hit;
        unit_out.res      = {16'd0, sum[`ALU_WORD_W-1:0]};
        unit_out.flags.cy = req.wide ? sum[16] : sum[8];
        unit_out.flags.ac = nib[4];
        unit_out.flags.v  = ovf;
        unit_out.mask.cy  = ~keep_cy;
        unit_out.mask.ac  = 1'b1;
        unit_out.mask.v   = 1'b1;
        unit_out.psz      = 1'b1;
    end

endmodule

/* src/alu_logic.sv */
`timescale 1ns/100ps
`include "alu_config.svh"

module alu_logic (
    input  alu_op_pkg::alu_req_t          req,
    output alu_flags_pkg::alu_unit_out_t  unit_out
);

    logic [`ALU_BIT_IDX_W-1:0] bit_idx;
    logic [`ALU_WORD_W-1:0]    bit_mask;

    // byte mode only reaches bits 0..7
    assign bit_idx  = req.wide ? req.tb[`ALU_BIT_IDX_W-1:0] : {1'b0, req.tb[2:0]};
    assign bit_mask = 16'd1 << bit_idx;

    always_comb begin
        unit_out       = '0;
        unit_out.valid = 1'b1;
        case (req.op)
            alu_op_pkg::ALU_OP_AND, alu_op_pkg::ALU_OP_OR, alu_op_pkg::ALU_OP_XOR: begin
                if (req.op == alu_op_pkg::ALU_OP_AND)
                    unit_out.res[15:0] = req.ta & req.tb;
                else if (req.op == alu_op_pkg::ALU_OP_OR)
                    unit_out.res[15:0] = req.ta | req.tb;
                else
                    unit_out.res[15:0] = req.ta ^ req.tb;
                unit_out.mask.cy = 1'b1;    // cy, ac, v written as zero
                unit_out.mask.ac = 1'b1;
                unit_out.mask.v  = 1'b1;
                unit_out.psz     = 1'b1;
            end
            alu_op_pkg::ALU_OP_NOT:  unit_out.res[15:0] = ~req.ta;
            alu_op_pkg::ALU_OP_SET1: unit_out.res[15:0] = req.ta | bit_mask;
            alu_op_pkg::ALU_OP_CLR1: unit_out.res[15:0] = req.ta & ~bit_mask;
            alu_op_pkg::ALU_OP_NOT1: unit_out.res[15:0] = req.ta ^ bit_mask;
            alu_op_pkg::ALU_OP_TEST1: begin
                unit_out.res[15:0] = req.ta & bit_mask;
                unit_out.flags.z   = ~|(req.ta & bit_mask);
                unit_out.mask.z    = 1'b1;
                unit_out.mask.cy   = 1'b1;
                unit_out.mask.v    = 1'b1;
            end
            default: unit_out.valid = 1'b0;
        endcase
    end

endmodule

/* src/alu_shift.sv */
`timescale 1ns/100ps
`include "alu_config.svh"

module alu_shift (
    input  alu_op_pkg::alu_req_t          req,
    output alu_flags_pkg::alu_unit_out_t  unit_out
);

    logic [`ALU_CNT_W-1:0]    cnt;
    logic [`ALU_CNT_W-1:0]    rc_w;      // count mod 17
    logic [`ALU_CNT_W-1:0]    rc_b;      // count mod 9
    logic [`ALU_WORD_W-1:0]   ta_m;
    logic [`ALU_WORD_W-1:0]   ta_s;
    logic [2*`ALU_WORD_W-1:0] dbl_w;
    logic [2*`ALU_BYTE_W-1:0] dbl_b;
    logic [2*`ALU_WORD_W+1:0] rc34;
    logic [2*`ALU_BYTE_W+1:0] rc18;
    logic [`ALU_WORD_W:0]     t17;
    logic [`ALU_WORD_W-1:0]   res;
    logic                     cy;
    logic                     v_zero;
    logic                     is_shift;
    logic                     top_a;
    logic                     top_r;

    assign cnt  = req.tb[`ALU_CNT_W-1:0];
    assign rc_w = cnt % 5'd17;
    assign rc_b = cnt % 5'd9;
    assign ta_m = req.wide ? req.ta : {8'd0, req.ta[7:0]};
    assign ta_s = req.wide ? req.ta : {{8{req.ta[7]}}, req.ta[7:0]};

    always_comb begin
        dbl_w          = '0;
        dbl_b          = '0;
        rc34           = '0;
        rc18           = '0;
        t17            = '0;
        res            = '0;
        cy             = req.flags_in.cy;
        v_zero         = 1'b0;
        is_shift       = 1'b0;
        unit_out       = '0;
        unit_out.valid = 1'b1;
        case (req.op)
            alu_op_pkg::ALU_OP_ROL, alu_op_pkg::ALU_OP_ROR: begin
                if (req.op == alu_op_pkg::ALU_OP_ROL) begin
                    dbl_w = {req.ta, req.ta} << cnt[3:0];
                    dbl_b = {req.ta[7:0], req.ta[7:0]} << cnt[2:0];
                    res   = req.wide ? dbl_w[31:16] : {8'd0, dbl_b[15:8]};
                    cy    = res[0];     // last bit out of the top lands in bit 0
                end else begin
                    dbl_w = {req.ta, req.ta} >> cnt[3:0];
                    dbl_b = {req.ta[7:0], req.ta[7:0]} >> cnt[2:0];
                    res   = req.wide ? dbl_w[15:0] : {8'd0, dbl_b[7:0]};
                    cy    = req.wide ? res[15] : res[7];
                end
            end
            alu_op_pkg::ALU_OP_ROLC, alu_op_pkg::ALU_OP_RORC: begin
                // carry rides along as bit 16 (or bit 8)
                rc34 = {req.flags_in.cy, req.ta, req.flags_in.cy, req.ta};
                rc18 = {req.flags_in.cy, req.ta[7:0], req.flags_in.cy, req.ta[7:0]};
                if (req.op == alu_op_pkg::ALU_OP_ROLC) begin
                    rc34 = rc34 << rc_w;
                    rc18 = rc18 << rc_b;
                    rc34[16:0] = rc34[33:17];
                    rc18[8:0]  = rc18[17:9];
                end else begin
                    rc34 = rc34 >> rc_w;
                    rc18 = rc18 >> rc_b;
                end
                res = req.wide ? rc34[15:0] : {8'd0, rc18[7:0]};
                cy  = req.wide ? rc34[16] : rc18[8];
            end
            alu_op_pkg::ALU_OP_SHL: begin
                t17      = {1'b0, ta_m} << cnt;
                res      = t17[15:0];
                cy       = req.wide ? t17[16] : t17[8];
                is_shift = 1'b1;
            end
            alu_op_pkg::ALU_OP_SHR: begin
                t17      = {ta_m, 1'b0} >> cnt;
                res      = t17[16:1];
                cy       = t17[0];
                is_shift = 1'b1;
            end
            alu_op_pkg::ALU_OP_SHRA: begin
                t17      = $signed({ta_s, 1'b0}) >>> cnt;
                res      = t17[16:1];
                cy       = t17[0];
                v_zero   = 1'b1;
                is_shift = 1'b1;
            end
            default: unit_out.valid = 1'b0;
        endcase

        top_a = req.wide ? req.ta[15] : req.ta[7];
        top_r = req.wide ? res[15] : res[7];

        unit_out.res      = {16'd0, res};
        unit_out.flags.cy = cy;
        unit_out.flags.v  = ~v_zero & (top_a ^ top_r);
        unit_out.mask.cy  = cnt != '0;     // nothing moved out on a zero count
        unit_out.mask.v   = 1'b1;
        unit_out.psz      = is_shift;
    end

endmodule

/* src/alu_mul.sv */
`timescale 1ns/100ps
`include "alu_config.svh"

module alu_mul (
    input  alu_op_pkg::alu_req_t          req,
    output alu_flags_pkg::alu_unit_out_t  unit_out
);

    logic        [`ALU_PROD_W-1:0]   uprod_w;
    logic        [2*`ALU_BYTE_W-1:0] uprod_b;
    logic signed [`ALU_PROD_W-1:0]   sprod_w;
    logic signed [2*`ALU_BYTE_W-1:0] sprod_b;
    logic                            ovf;

    assign uprod_w = req.ta * req.tb;
    assign uprod_b = req.ta[7:0] * req.tb[7:0];
    assign sprod_w = $signed(req.ta) * $signed(req.tb);
    assign sprod_b = $signed(req.ta[7:0]) * $signed(req.tb[7:0]);

    always_comb begin
        unit_out       = '0;
        unit_out.valid = 1'b1;
        ovf            = 1'b0;
        case (req.op)
            alu_op_pkg::ALU_OP_MULU: begin
                unit_out.res = req.wide ? uprod_w : {16'd0, uprod_b};
                ovf = req.wide ? |uprod_w[31:16] : |uprod_b[15:8];
            end
            alu_op_pkg::ALU_OP_MUL: begin
                // byte product kept as 16 bits with the upper word zero
                unit_out.res = req.wide ? sprod_w : {16'd0, sprod_b};
                ovf = req.wide ? (sprod_w[31:16] != {16{sprod_w[15]}})
                               : (sprod_b[15:8] != {8{sprod_b[7]}});
            end
            default: unit_out.valid = 1'b0;
        endcase
        unit_out.flags.cy = ovf;
        unit_out.flags.v  = ovf;
        unit_out.mask.cy  = 1'b1;
        unit_out.mask.v   = 1'b1;
    end

endmodule

/* src/alu_result_reg.sv */
`timescale 1ns/100ps
`include "alu_config.svh"

module alu_result_reg (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         ce,
    input  logic                         execute,
    input  logic                         wide,
    input  alu_flags_pkg::alu_flags_t    flags_in,
    input  alu_flags_pkg::alu_unit_out_t arith_out,
    input  alu_flags_pkg::alu_unit_out_t logic_out,
    input  alu_flags_pkg::alu_unit_out_t shift_out,
    input  alu_flags_pkg::alu_unit_out_t mul_out,
    output logic [`ALU_PROD_W-1:0]       result,
    output alu_flags_pkg::alu_flags_t    flags,
    output logic                         done
);

    alu_flags_pkg::alu_unit_out_t sel;
    alu_flags_pkg::alu_flags_t    next_flags;
    logic [`ALU_PROD_W-1:0]       next_result;
    logic                         hit;
    logic                         accept;

    // at most one unit answers
    always_comb begin
        if (arith_out.valid)
            sel = arith_out;
        else if (logic_out.valid)
            sel = logic_out;
        else if (shift_out.valid)
            sel = shift_out;
        else
            sel = mul_out;
    end

    assign hit    = arith_out.valid | logic_out.valid | shift_out.valid | mul_out.valid;
    assign accept = ce & execute & hit;

    always_comb begin
        if (mul_out.valid)
            next_result = sel.res;          // full product
        else if (wide)
            next_result = {16'd0, sel.res[`ALU_WORD_W-1:0]};
        else
            next_result = {24'd0, sel.res[`ALU_BYTE_W-1:0]};

        next_flags = (flags_in & ~sel.mask) | (sel.flags & sel.mask);
        if (sel.psz) begin
            next_flags.p = ~^next_result[7:0];  // even parity
            next_flags.s = wide ? next_result[15] : next_result[7];
            next_flags.z = wide ? (next_result[15:0] == '0) : (next_result[7:0] == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
            flags  <= '0;
            done   <= 1'b0;
        end else begin
            done <= accept;     // cleared on any idle or ce-low cycle
            if (accept) begin
                result <= next_result;
                flags  <= next_flags;
            end
        end
    end

endmodule

/* src/alu_top.sv */
`timescale 1ns/100ps
`include "alu_config.svh"

module alu_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      ce,
    input  logic                      execute,
    input  alu_op_pkg::alu_op_e       operation,
    input  logic [`ALU_WORD_W-1:0]    ta,
    input  logic [`ALU_WORD_W-1:0]    tb,
    input  logic                      wide,
    input  alu_flags_pkg::alu_flags_t flags_in,
    output logic [`ALU_PROD_W-1:0]    result,
    output alu_flags_pkg::alu_flags_t flags,
    output logic                      done
);

    alu_op_pkg::alu_req_t         req;
    alu_flags_pkg::alu_unit_out_t arith_out;
    alu_flags_pkg::alu_unit_out_t logic_out;
    alu_flags_pkg::alu_unit_out_t shift_out;
    alu_flags_pkg::alu_unit_out_t mul_out;

    always_comb begin
        req.op       = operation;
        req.ta       = ta;
        req.tb       = tb;
        req.wide     = wide;
        req.flags_in = flags_in;
    end

    // four combinational units in parallel
    alu_arith u_arith (.req(req), .unit_out(arith_out));
    alu_logic u_logic (.req(req), .unit_out(logic_out));
    alu_shift u_shift (.req(req), .unit_out(shift_out));
    alu_mul   u_mul   (.req(req), .unit_out(mul_out));

    alu_result_reg u_result_reg (
        .clk       (clk),
        .reset     (reset),
        .ce        (ce),
        .execute   (execute),
        .wide      (wide),
        .flags_in  (flags_in),
        .arith_out (arith_out),
        .logic_out (logic_out),
        .shift_out (shift_out),
        .mul_out   (mul_out),
        .result    (result),
        .flags     (flags),
        .done      (done)
    );

endmodule

/* verif/alu_assert.sv */
`timescale 1ns/100ps

module alu_assert (
    input logic                clk,
    input logic                reset,
    input logic                ce,
    input logic                execute,
    input alu_op_pkg::alu_op_e operation,
    input logic                done
);

    logic known;    // some unit owns the opcode

    assign known = (operation <= alu_op_pkg::ALU_OP_MUL);

    // accepted request shows done on the next edge
    a_done_after_accept: assert property (
        @(posedge clk) disable iff (reset) (ce && execute && known) |=> done
    ) else $error("done missing one cycle after an accepted request");

    a_done_only_after_accept: assert property (
        @(posedge clk) disable iff (reset) done |-> $past(ce && execute && known)
    ) else $error("done without an accepted request one cycle before");

    a_reset_clears_done: assert property (
        @(posedge clk) reset |=> !done
    ) else $error("done high during or right after reset");

    a_done_needs_ce: assert property (
        @(posedge clk) done |-> $past(ce)
    ) else $error("done without ce high in the cycle before");

endmodule

/* verif/alu_tb.sv */
`timescale 1ns/100ps
`include "alu_config.svh"

module alu_tb;

    logic                      clk;
    logic                      reset;
    logic                      ce;
    logic                      execute;
    alu_op_pkg::alu_op_e       operation;
    logic [`ALU_WORD_W-1:0]    ta;
    logic [`ALU_WORD_W-1:0]    tb;
    logic                      wide;
    alu_flags_pkg::alu_flags_t flags_in;
    logic [`ALU_PROD_W-1:0]    result;
    alu_flags_pkg::alu_flags_t flags;
    logic                      done;

    int   errors;        // every mismatch or other failure
    int   tests_run;
    int   tests_failed;
    logic test_bad;

    alu_top UUT (
        .clk      (clk),
        .reset    (reset),
        .ce       (ce),
        .execute  (execute),
        .operation(operation),
        .ta       (ta),
        .tb       (tb),
        .wide     (wide),
        .flags_in (flags_in),
        .result   (result),
        .flags    (flags),
        .done     (done)
    );

    bind alu_top alu_assert u_alu_assert (
        .clk      (clk),
        .reset    (reset),
        .ce       (ce),
        .execute  (execute),
        .operation(operation),
        .done     (done)
    );

    always #5 clk = ~clk;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            errors   = errors + 1;
            test_bad = 1'b1;
        end
    endtask

    task automatic apply_reset;
        reset = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    endtask

    // 0..3 cycles with no request, ce toggled at random
    task automatic idle_cycles;
        int unsigned n;
        int unsigned rnd;
        n = $urandom % 4;
        repeat (n) begin
            @(negedge clk);
            rnd     = $urandom;
            execute = 1'b0;
            ce      = rnd[0];
        end
    endtask

    task automatic run_test(
        input int          op_code,
        input logic [31:0] wide_v,
        input logic [31:0] ce_v,
        input logic [31:0] ta_v,
        input logic [31:0] tb_v,
        input logic [31:0] fin_v,
        input logic [31:0] exp_done,
        input logic [31:0] exp_res,
        input logic [31:0] exp_flags
    );
        int   wait_cnt;
        logic seen;
        test_bad  = 1'b0;
        tests_run = tests_run + 1;
        idle_cycles();
        @(negedge clk);
        operation = alu_op_pkg::alu_op_e'(op_code[4:0]);
        wide      = wide_v[0];
        ta        = ta_v[15:0];
        tb        = tb_v[15:0];
        flags_in  = alu_flags_pkg::alu_flags_t'(fin_v[5:0]);
        ce        = ce_v[0];
        execute   = 1'b1;
        wait_cnt  = 0;
        seen      = 1'b0;
        while (!seen && wait_cnt < 20) begin
            @(negedge clk);
            seen     = done;    // sampled mid-cycle
            execute  = 1'b0;
            ce       = 1'b1;
            wait_cnt = wait_cnt + 1;
        end
        if (exp_done[0] && !seen) begin
            $display("test %0d: no done within 20 cycles", tests_run);
            errors   = errors + 1;
            test_bad = 1'b1;
        end else if (!exp_done[0] && seen) begin
            $display("test %0d: done raised for a request that must be ignored", tests_run);
            errors   = errors + 1;
            test_bad = 1'b1;
        end
        compare_value("result", result, exp_res);
        compare_value("flags", {26'd0, flags}, exp_flags);
        if (test_bad)
            tests_failed = tests_failed + 1;
        $display("test %0d op %0d wide %0d: %s", tests_run, op_code, wide_v[0],
                 test_bad ? "FAILED" : "ok");
    endtask

    initial begin
        int          fd;
        int          code;
        int          n;
        int          op_code;
        string       line;
        logic [31:0] wide_v;
        logic [31:0] ce_v;
        logic [31:0] ta_v;
        logic [31:0] tb_v;
        logic [31:0] fin_v;
        logic [31:0] exp_done;
        logic [31:0] exp_res;
        logic [31:0] exp_flags;

        clk          = 1'b0;
        reset        = 1'b1;
        ce           = 1'b0;
        execute      = 1'b0;
        operation    = alu_op_pkg::ALU_OP_ADD;
        ta           = '0;
        tb           = '0;
        wide         = 1'b0;
        flags_in     = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_bad     = 1'b0;
        void'($urandom(80));

        apply_reset();
        compare_value("done", {31'd0, done}, 32'd0);
        compare_value("result", result, 32'd0);
        compare_value("flags", {26'd0, flags}, 32'd0);
        $display("reset check: %s", test_bad ? "FAILED" : "ok");

        fd = $fopen("verif/alu_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open verif/alu_stimulus.txt");
            errors = errors + 1;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                // skip blank and comment lines
                if (code > 1 && line.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%d %h %h %h %h %h %h %h %h", op_code, wide_v, ce_v,
                                ta_v, tb_v, fin_v, exp_done, exp_res, exp_flags);
                    if (n == 9) begin
                        run_test(op_code, wide_v, ce_v, ta_v, tb_v, fin_v,
                                 exp_done, exp_res, exp_flags);
                    end else begin
                        $display("stimulus line could not be read: %s", line);
                        errors = errors + 1;
                    end
                end
            end
            $fclose(fd);
        end

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0 && tests_run > 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

/* verif/alu_stimulus.txt */
# op(decimal) wide ce ta tb flags_in done result flags, all hex except op
# flags bits from 5 down to 0: cy p ac z s v
0  1 1 1234 4321 00 1 00005555 10
0  1 1 7fff 0001 00 1 00008000 1b
0  0 1 12ff 3401 00 1 00000000 3c
1  1 1 ffff 0000 20 1 00000000 3c
1  0 1 0040 003f 20 1 00000080 0b
2  1 1 00ff 0000 20 1 00000100 38
3  1 1 0005 0007 00 1 0000fffe 2a
3  1 1 8000 0001 00 1 00007fff 19
4  0 1 0010 0001 20 1 0000000e 08
5  0 1 0042 0042 00 1 00000000 14
6  1 1 0000 0000 20 1 0000ffff 3a
7  1 1 0001 0000 00 1 0000ffff 3a
7  1 1 8000 0000 00 1 00008000 33
8  1 1 f0f0 ff00 3f 1 0000f000 12
9  0 1 1200 3400 29 1 00000000 14
10 1 1 aaaa 5555 00 1 0000ffff 12
11 1 1 00ff 0000 2d 1 0000ff00 2d
12 1 1 0000 000f 00 1 00008000 00
13 0 1 00ff 000b 05 1 000000f7 05
14 1 1 1234 0004 3f 1 00001224 3f
15 1 1 0100 0008 3f 1 00000100 1a
15 0 1 00f7 0003 00 1 00000000 04
16 1 1 8001 0001 00 1 00000003 21
16 1 1 8001 0000 20 1 00008001 20
16 0 1 0081 0007 00 1 000000c0 00
18 1 1 1234 0008 00 1 00003412 00
18 1 1 8000 000f 00 1 00000001 01
17 1 1 8000 0001 20 1 00000001 21
19 0 1 0001 0001 00 1 00000000 20
20 1 1 c000 0001 00 1 00008000 32
20 0 1 00ff 0008 00 1 00000000 35
21 1 1 8080 0007 00 1 00000101 01
22 0 1 0081 0001 00 1 000000c0 32
22 1 1 8000 000f 00 1 0000ffff 12
23 1 1 ffff ffff 00 1 fffe0001 21
23 0 1 0010 0010 00 1 00000100 21
24 1 1 fffe 0003 00 1 fffffffa 00
24 0 1 0080 0080 00 1 00004000 21
24 1 1 4000 0004 00 1 00010000 21
25 1 1 1111 2222 00 0 00010000 21
0  1 0 0001 0001 00 0 00010000 21
8  1 1 ffff 0f0f 00 1 00000f0f 10

/* tb.f */
+incdir+include
src/alu_flags_pkg.sv
src/alu_op_pkg.sv
src/alu_arith.sv
src/alu_logic.sv
src/alu_shift.sv
src/alu_mul.sv
src/alu_result_reg.sv
src/alu_top.sv
verif/alu_assert.sv
verif/alu_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = alu_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
